/* Makefile */
TOP := tb_cpu_core

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f list.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

/* list.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_ifs.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/regfile_2r1w.sv
rtl/hazard_ctrl.sv
rtl/cpu_core.sv
verification/tb_cpu_core.sv

/* rtl/cpu_core.sv */
module cpu_core #(
    parameter logic [31:0] RESET_PC = isa_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        inst_sram_rdata,
    input  logic [31:0]        data_sram_rdata,
    output logic               inst_sram_en,
    output logic [31:0]        inst_sram_addr,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output logic [31:0]        data_sram_addr,
    output logic [31:0]        data_sram_wdata,
    output logic [31:0]        debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output isa_pkg::reg_addr_t debug_wb_rf_wnum,
    output logic [31:0]        debug_wb_rf_wdata
);
    logic               stall, uses_rt, br_taken, br_is_j;
    logic [15:0]        br_offset;
    logic [25:0]        br_index;
    logic [31:0]        fe_pc, de_pc, de_vsrc1, de_vsrc2, de_st_value;
    logic [31:0]        rf_rdata1, rf_rdata2, de_data1, de_data2;
    isa_pkg::reg_addr_t raddr1, raddr2, de_dest;
    pipe_pkg::alu_op_e  de_alu_op;
    pipe_pkg::mem_op_e  de_mem_op;

    stage_result_if ex_res ();
    stage_result_if mem_res ();
    wb_port_if      wb_port ();

    fetch_stage #(.RESET_PC(RESET_PC)) i_fetch_stage (
        .clk, .rst_n, .stall, .br_taken, .br_is_j, .br_offset, .br_index,
        .inst_sram_en, .inst_sram_addr, .fe_pc
    );

    decode_stage i_decode_stage (
        .clk, .rst_n, .stall, .fe_pc, .inst_sram_rdata,
        .rdata1 (de_data1),
        .rdata2 (de_data2),
        .raddr1, .raddr2, .uses_rt, .br_taken, .br_is_j, .br_offset, .br_index,
        .de_alu_op, .de_mem_op, .de_dest, .de_vsrc1, .de_vsrc2, .de_st_value, .de_pc
    );

    execute_stage i_execute_stage (
        .clk, .rst_n, .de_alu_op, .de_mem_op, .de_dest, .de_vsrc1, .de_vsrc2,
        .de_st_value, .de_pc,
        .data_sram_en, .data_sram_wen, .data_sram_addr, .data_sram_wdata,
        .ex_res (ex_res.src)
    );

    mem_wb_stage i_mem_wb_stage (
        .clk, .rst_n, .data_sram_rdata,
        .ex_res  (ex_res.snoop),
        .mem_res (mem_res.src),
        .wb      (wb_port.src),
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    regfile_2r1w i_regfile (
        .clk, .rst_n, .raddr1, .raddr2,
        .wb     (wb_port.sink),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    hazard_ctrl i_hazard_ctrl (
        .raddr1, .raddr2, .uses_rt, .rf_rdata1, .rf_rdata2,
        .ex_res  (ex_res.snoop),
        .mem_res (mem_res.snoop),
        .wb      (wb_port.sink),
        .de_data1, .de_data2, .stall
    );

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic [31:0]         fe_pc,
    input  logic [31:0]         inst_sram_rdata,
    input  logic [31:0]         rdata1,
    input  logic [31:0]         rdata2,
    output isa_pkg::reg_addr_t  raddr1,
    output isa_pkg::reg_addr_t  raddr2,
    output logic                uses_rt,
    output logic                br_taken,
    output logic                br_is_j,
    output logic [15:0]         br_offset,
    output logic [25:0]         br_index,
    output pipe_pkg::alu_op_e   de_alu_op,
    output pipe_pkg::mem_op_e   de_mem_op,
    output isa_pkg::reg_addr_t  de_dest,
    output logic [31:0]         de_vsrc1,
    output logic [31:0]         de_vsrc2,
    output logic [31:0]         de_st_value,
    output logic [31:0]         de_pc
);
    isa_pkg::inst_word_u inst;
    isa_pkg::reg_addr_t  dest;
    pipe_pkg::alu_op_e   alu_op;
    pipe_pkg::mem_op_e   mem_op;
    logic [31:0]         vsrc1, vsrc2, imm_sext, imm_zext;
    logic                inst_valid;    // Low for the word fetched during reset
    logic                is_beq, is_bne, is_j;

    assign inst     = inst_sram_rdata;
    assign raddr1   = inst.r.rs;
    assign raddr2   = inst.r.rt;
    assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};
    assign imm_zext = {16'h0, inst.i.imm};

    always_comb begin
        alu_op  = pipe_pkg::ALU_ADD;
        mem_op  = pipe_pkg::MEM_NONE;
        dest    = '0;
        vsrc1   = rdata1;
        vsrc2   = rdata2;
        uses_rt = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_j    = 1'b0;
        if (inst_valid) begin
            case (inst.i.opcode)
                isa_pkg::OP_SPECIAL: begin
                    dest    = inst.r.rd;
                    uses_rt = 1'b1;
                    case (inst.r.funct)
                        isa_pkg::FN_ADDU: alu_op = pipe_pkg::ALU_ADD;
                        isa_pkg::FN_SUBU: alu_op = pipe_pkg::ALU_SUB;
                        isa_pkg::FN_AND:  alu_op = pipe_pkg::ALU_AND;
                        isa_pkg::FN_OR:   alu_op = pipe_pkg::ALU_OR;
                        isa_pkg::FN_SLT:  alu_op = pipe_pkg::ALU_SLT;
                        isa_pkg::FN_SLL: begin
                            alu_op = pipe_pkg::ALU_SLL;
                            vsrc1  = {27'h0, inst.r.shamt};
                        end
                        default: dest = '0;    // Unsupported funct acts as nop
                    endcase
                end
                isa_pkg::OP_ADDIU: begin
                    dest  = inst.i.rt;
                    vsrc2 = imm_sext;
                end
                isa_pkg::OP_LUI: begin
                    alu_op = pipe_pkg::ALU_LUI;
                    dest   = inst.i.rt;
                    vsrc2  = imm_zext;
                end
                isa_pkg::OP_ORI: begin
                    alu_op = pipe_pkg::ALU_OR;
                    dest   = inst.i.rt;
                    vsrc2  = imm_zext;
                end
                isa_pkg::OP_LW: begin
                    mem_op = pipe_pkg::MEM_LOAD;
                    dest   = inst.i.rt;
                    vsrc2  = imm_sext;
                end
                isa_pkg::OP_SW: begin
                    mem_op  = pipe_pkg::MEM_STORE;
                    uses_rt = 1'b1;
                    vsrc2   = imm_sext;
                end
                isa_pkg::OP_BEQ: begin
                    is_beq  = 1'b1;
                    uses_rt = 1'b1;
                end
                isa_pkg::OP_BNE: begin
                    is_bne  = 1'b1;
                    uses_rt = 1'b1;
                end
                isa_pkg::OP_J: is_j = 1'b1;
                default: ;
            endcase
        end
    end

    // Operands arrive already forwarded
    assign br_taken  = is_j | (is_beq & (rdata1 == rdata2)) | (is_bne & (rdata1 != rdata2));
    assign br_is_j   = is_j;
    assign br_offset = inst.i.imm;
    assign br_index  = {inst.i.rs, inst.i.rt, inst.i.imm};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_valid <= 1'b0;
            de_dest    <= '0;
            de_mem_op  <= pipe_pkg::MEM_NONE;
        end else begin
            inst_valid <= 1'b1;
            de_dest    <= stall ? '0 : dest;    // Bubble
            de_mem_op  <= stall ? pipe_pkg::MEM_NONE : mem_op;
        end
    end

    always_ff @(posedge clk) begin
        de_alu_op   <= alu_op;
        de_vsrc1    <= vsrc1;
        de_vsrc2    <= vsrc2;
        de_st_value <= rdata2;
        de_pc       <= fe_pc;
    end

    // The bubble clears the load from execute
    a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall);

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::alu_op_e  de_alu_op,
    input  pipe_pkg::mem_op_e  de_mem_op,
    input  isa_pkg::reg_addr_t de_dest,
    input  logic [31:0]        de_vsrc1,
    input  logic [31:0]        de_vsrc2,
    input  logic [31:0]        de_st_value,
    input  logic [31:0]        de_pc,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output logic [31:0]        data_sram_addr,
    output logic [31:0]        data_sram_wdata,
    stage_result_if.src        ex_res
);
    logic [31:0] alu_result;

    always_comb begin
        case (de_alu_op)
            pipe_pkg::ALU_SUB: alu_result = de_vsrc1 - de_vsrc2;
            pipe_pkg::ALU_AND: alu_result = de_vsrc1 & de_vsrc2;
            pipe_pkg::ALU_OR:  alu_result = de_vsrc1 | de_vsrc2;
            pipe_pkg::ALU_SLT: alu_result = {31'h0, $signed(de_vsrc1) < $signed(de_vsrc2)};
            pipe_pkg::ALU_SLL: alu_result = de_vsrc2 << de_vsrc1[4:0];
            pipe_pkg::ALU_LUI: alu_result = {de_vsrc2[15:0], 16'h0};
            default:           alu_result = de_vsrc1 + de_vsrc2;
        endcase
    end

    // Word accesses only
    assign data_sram_en    = (de_mem_op != pipe_pkg::MEM_NONE);
    assign data_sram_wen   = (de_mem_op == pipe_pkg::MEM_STORE) ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = de_st_value;

    assign ex_res.valid   = (de_dest != '0);
    assign ex_res.dest    = de_dest;
    assign ex_res.value   = alu_result;
    assign ex_res.is_load = (de_mem_op == pipe_pkg::MEM_LOAD);
    assign ex_res.pc      = de_pc;

    a_word_access: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_en |-> (data_sram_addr[1:0] == 2'b00));

endmodule

/* rtl/fetch_stage.sv */
module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        br_taken,
    input  logic        br_is_j,
    input  logic [15:0] br_offset,
    input  logic [25:0] br_index,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] fe_pc
);
    logic [31:0] seq_pc, br_target, j_target, nextpc, pend_target;
    logic        pend_valid;    // Redirect waits until the delay slot is fetched

    assign seq_pc    = fe_pc + 32'd4;
    assign br_target = seq_pc + {{14{br_offset[15]}}, br_offset, 2'b00};
    assign j_target  = {seq_pc[31:28], br_index, 2'b00};
    assign nextpc    = pend_valid ? pend_target : seq_pc;

    assign inst_sram_en   = 1'b1;
    assign inst_sram_addr = stall ? fe_pc : nextpc;    // Refetch the held word

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fe_pc      <= RESET_PC - 32'd4;
            pend_valid <= 1'b0;
        end else if (!stall) begin
            fe_pc      <= nextpc;
            pend_valid <= br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pend_target <= br_is_j ? j_target : br_target;
        end
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        inst_sram_addr[1:0] == 2'b00);

endmodule

/* rtl/hazard_ctrl.sv */
module hazard_ctrl (
    input  isa_pkg::reg_addr_t raddr1,
    input  isa_pkg::reg_addr_t raddr2,
    input  logic               uses_rt,
    input  logic [31:0]        rf_rdata1,
    input  logic [31:0]        rf_rdata2,
    stage_result_if.snoop      ex_res,
    stage_result_if.snoop      mem_res,
    wb_port_if.sink            wb,
    output logic [31:0]        de_data1,
    output logic [31:0]        de_data2,
    output logic               stall
);
    logic ex_hit1, ex_hit2, mem_hit1, mem_hit2, wb_hit1, wb_hit2;

    // Producers never carry dest zero when valid
    assign ex_hit1  = ex_res.valid && ex_res.dest == raddr1;
    assign ex_hit2  = ex_res.valid && ex_res.dest == raddr2;
    assign mem_hit1 = mem_res.valid && mem_res.dest == raddr1;
    assign mem_hit2 = mem_res.valid && mem_res.dest == raddr2;
    assign wb_hit1  = wb.wen && wb.waddr == raddr1;
    assign wb_hit2  = wb.wen && wb.waddr == raddr2;

    always_comb begin
        if (ex_hit1)       de_data1 = ex_res.value;
        else if (mem_hit1) de_data1 = mem_res.value;
        else if (wb_hit1)  de_data1 = wb.wdata;
        else               de_data1 = rf_rdata1;
    end

    always_comb begin
        if (ex_hit2)       de_data2 = ex_res.value;
        else if (mem_hit2) de_data2 = mem_res.value;
        else if (wb_hit2)  de_data2 = wb.wdata;
        else               de_data2 = rf_rdata2;
    end

    // Load data is not back until the memory stage
    assign stall = ex_res.is_load && (ex_hit1 || (uses_rt && ex_hit2));

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

    typedef logic [4:0] reg_addr_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_u;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [31:0] RESET_VECTOR_DEFAULT = 32'hbfc00000;

endpackage

/* rtl/mem_wb_stage.sv */
module mem_wb_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         data_sram_rdata,
    stage_result_if.snoop       ex_res,
    stage_result_if.src         mem_res,
    wb_port_if.src              wb,
    output logic [31:0]         debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output isa_pkg::reg_addr_t  debug_wb_rf_wnum,
    output logic [31:0]         debug_wb_rf_wdata
);
    logic               m_valid, m_is_load, w_valid;
    isa_pkg::reg_addr_t m_dest, w_dest;
    logic [31:0]        m_value, m_pc, w_value, w_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            m_valid <= ex_res.valid;
            w_valid <= mem_res.valid;
        end
    end

    always_ff @(posedge clk) begin
        m_dest    <= ex_res.dest;
        m_value   <= ex_res.value;
        m_is_load <= ex_res.is_load;
        m_pc      <= ex_res.pc;
        w_dest    <= mem_res.dest;
        w_value   <= mem_res.value;
        w_pc      <= mem_res.pc;
    end

    assign mem_res.valid   = m_valid;
    assign mem_res.dest    = m_dest;
    assign mem_res.value   = m_is_load ? data_sram_rdata : m_value;    // Load data lands here
    assign mem_res.is_load = m_is_load;
    assign mem_res.pc      = m_pc;

    assign wb.wen   = w_valid;
    assign wb.waddr = w_dest;
    assign wb.wdata = w_value;

    assign debug_wb_pc       = w_pc;
    assign debug_wb_rf_wen   = {4{w_valid}};    // valid already excludes r0
    assign debug_wb_rf_wnum  = w_dest;
    assign debug_wb_rf_wdata = w_value;

endmodule

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    // ALU function selected in decode
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_SLL = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

endpackage

/* rtl/regfile_2r1w.sv */
module regfile_2r1w (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_addr_t raddr1,
    input  isa_pkg::reg_addr_t raddr2,
    wb_port_if.sink            wb,
    output logic [31:0]        rdata1,
    output logic [31:0]        rdata2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wb.wen && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // Old value on a same-cycle write
    assign rdata1 = (raddr1 == '0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'h0 : regs[raddr2];

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb.wen |-> (wb.waddr != '0));

endmodule

/* rtl/stage_ifs.sv */
interface stage_result_if;
    logic                valid;    // Result targets a nonzero register
    isa_pkg::reg_addr_t  dest;
    logic [31:0]         value;
    logic                is_load;
    logic [31:0]         pc;

    modport src (
        output valid,
        output dest,
        output value,
        output is_load,
        output pc
    );

    modport snoop (
        input valid,
        input dest,
        input value,
        input is_load,
        input pc
    );
endinterface

interface wb_port_if;
    logic               wen;
    isa_pkg::reg_addr_t waddr;
    logic [31:0]        wdata;

    modport src  (output wen, output waddr, output wdata);
    modport sink (input  wen, input  waddr, input  wdata);
endinterface

/* verification/tb_cpu_core.sv */
module tb_cpu_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN       = 38;
    localparam int TIMEOUT_CYCLES = 16 + 4 * PROG_LEN + 20;

    typedef struct packed {
        logic [31:0]        pc;
        isa_pkg::reg_addr_t num;
        logic [31:0]        value;
    } trace_entry_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_entry_t;

    logic               clk;
    logic               rst_n;
    logic [31:0]        inst_sram_rdata;
    logic [31:0]        data_sram_rdata;
    logic               inst_sram_en;
    logic [31:0]        inst_sram_addr;
    logic               data_sram_en;
    logic [3:0]         data_sram_wen;
    logic [31:0]        data_sram_addr;
    logic [31:0]        data_sram_wdata;
    logic [31:0]        debug_wb_pc;
    logic [3:0]         debug_wb_rf_wen;
    isa_pkg::reg_addr_t debug_wb_rf_wnum;
    logic [31:0]        debug_wb_rf_wdata;

    logic [31:0]  prog [PROG_LEN];
    logic [31:0]  dram [1024];
    trace_entry_t exp_trace[$];
    store_entry_t exp_store[$];
    int           cycles = 0;
    int           loads_seen = 0;
    int           stores_seen = 0;

    logic        i_en_q, d_en_q;    // Requests captured mid-cycle
    logic [3:0]  d_wen_q;
    logic [31:0] i_addr_q, d_addr_q, d_wdata_q;

    cpu_core #(.RESET_PC(isa_pkg::RESET_VECTOR_DEFAULT)) i_cpu_core (
        .clk, .rst_n, .inst_sram_rdata, .data_sram_rdata,
        .inst_sram_en, .inst_sram_addr,
        .data_sram_en, .data_sram_wen, .data_sram_addr, .data_sram_wdata,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL t=%0t %s expected=%h actual=%h",
                                $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] pc_of(input int idx);
        return isa_pkg::RESET_VECTOR_DEFAULT + 32'(idx * 4);
    endfunction

    function automatic logic [31:0] r_type_word(input isa_pkg::reg_addr_t rs,
            input isa_pkg::reg_addr_t rt, input isa_pkg::reg_addr_t rd,
            input logic [4:0] shamt, input logic [5:0] funct);
        return {isa_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] op,
            input isa_pkg::reg_addr_t rs, input isa_pkg::reg_addr_t rt,
            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input int to_idx);
        logic [31:0] target;
        target = pc_of(to_idx);
        return {isa_pkg::OP_J, target[27:2]};
    endfunction

    // Word offset counted from the delay slot
    function automatic logic [15:0] branch_offset(input int from_idx, input int to_idx);
        return 16'(to_idx - from_idx - 1);
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] offset;
        int          idx;
        offset = addr - isa_pkg::RESET_VECTOR_DEFAULT;
        idx    = int'(offset[31:2]);
        if (offset[1:0] == 2'b00 && offset < 32'(PROG_LEN * 4)) begin
            return prog[idx];
        end
        return 32'h0;    // Nop outside the program
    endfunction

    task automatic expect_write(input int idx, input isa_pkg::reg_addr_t num,
                                input logic [31:0] value);
        trace_entry_t e;
        e.pc    = pc_of(idx);
        e.num   = num;
        e.value = value;
        exp_trace.push_back(e);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        store_entry_t s;
        s.addr = addr;
        s.data = data;
        exp_store.push_back(s);
    endtask

    task automatic build_program();
        prog[0]  = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd5);
        prog[1]  = i_type_word(isa_pkg::OP_ADDIU, 5'd1, 5'd2, 16'hfffd);    // From execute
        prog[2]  = i_type_word(isa_pkg::OP_LUI, 5'd0, 5'd3, 16'h1234);
        prog[3]  = i_type_word(isa_pkg::OP_ORI, 5'd3, 5'd3, 16'h5678);
        prog[4]  = r_type_word(5'd1, 5'd2, 5'd4, 5'd0, isa_pkg::FN_ADDU);    // From writeback
        prog[5]  = r_type_word(5'd3, 5'd1, 5'd5, 5'd0, isa_pkg::FN_SUBU);    // From memory
        prog[6]  = r_type_word(5'd3, 5'd5, 5'd6, 5'd0, isa_pkg::FN_AND);
        prog[7]  = r_type_word(5'd1, 5'd2, 5'd7, 5'd0, isa_pkg::FN_OR);
        prog[8]  = r_type_word(5'd2, 5'd1, 5'd8, 5'd0, isa_pkg::FN_SLT);
        prog[9]  = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'hffff);
        prog[10] = r_type_word(5'd9, 5'd1, 5'd10, 5'd0, isa_pkg::FN_SLT);    // Signed compare
        prog[11] = r_type_word(5'd1, 5'd9, 5'd11, 5'd0, isa_pkg::FN_SLT);
        prog[12] = r_type_word(5'd0, 5'd1, 5'd12, 5'd4, isa_pkg::FN_SLL);
        prog[13] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd13, 16'h0100);
        prog[14] = i_type_word(isa_pkg::OP_SW, 5'd13, 5'd3, 16'd0);
        prog[15] = i_type_word(isa_pkg::OP_SW, 5'd13, 5'd12, 16'd4);
        prog[16] = i_type_word(isa_pkg::OP_LW, 5'd13, 5'd14, 16'd0);
        prog[17] = r_type_word(5'd14, 5'd1, 5'd15, 5'd0, isa_pkg::FN_ADDU);    // Load-use on rs
        prog[18] = i_type_word(isa_pkg::OP_LW, 5'd13, 5'd16, 16'd4);
        prog[19] = i_type_word(isa_pkg::OP_SW, 5'd13, 5'd16, 16'd8);    // Load-use on store data
        prog[20] = i_type_word(isa_pkg::OP_LW, 5'd13, 5'd17, 16'd8);
        prog[21] = r_type_word(5'd0, 5'd17, 5'd18, 5'd0, isa_pkg::FN_OR);
        prog[22] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd0, 16'd7);    // Write to r0
        prog[23] = r_type_word(5'd0, 5'd1, 5'd19, 5'd0, isa_pkg::FN_ADDU);
        prog[24] = i_type_word(isa_pkg::OP_BEQ, 5'd1, 5'd7, branch_offset(24, 28));
        prog[25] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd20, 16'd1);
        prog[26] = i_type_word(isa_pkg::OP_BNE, 5'd20, 5'd0, branch_offset(26, 29));
        prog[27] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd21, 16'd2);
        prog[28] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd22, 16'h0099);    // Skipped
        prog[29] = i_type_word(isa_pkg::OP_BEQ, 5'd4, 5'd7, branch_offset(29, 32));
        prog[30] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd23, 16'd3);
        prog[31] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd22, 16'h0098);    // Skipped
        prog[32] = i_type_word(isa_pkg::OP_BNE, 5'd8, 5'd10, branch_offset(32, 36));
        prog[33] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd24, 16'd4);
        prog[34] = jump_word(37);
        prog[35] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd25, 16'd5);
        prog[36] = i_type_word(isa_pkg::OP_ADDIU, 5'd0, 5'd22, 16'h0097);    // Skipped
        prog[37] = i_type_word(isa_pkg::OP_ADDIU, 5'd25, 5'd26, 16'd1);
    endtask

    task automatic build_expected();
        expect_write(0, 5'd1, 32'd5);
        expect_write(1, 5'd2, 32'd5 - 32'd3);
        expect_write(2, 5'd3, 32'h1234_0000);
        expect_write(3, 5'd3, 32'h1234_0000 | 32'h5678);
        expect_write(4, 5'd4, 32'd5 + 32'd2);
        expect_write(5, 5'd5, 32'h1234_5678 - 32'd5);
        expect_write(6, 5'd6, 32'h1234_5678 & 32'h1234_5673);
        expect_write(7, 5'd7, 32'd5 | 32'd2);
        expect_write(8, 5'd8, 32'd1);
        expect_write(9, 5'd9, 32'hffff_ffff);
        expect_write(10, 5'd10, 32'd1);
        expect_write(11, 5'd11, 32'd0);
        expect_write(12, 5'd12, 32'd5 << 4);
        expect_write(13, 5'd13, 32'h100);
        expect_write(16, 5'd14, 32'h1234_5678);
        expect_write(17, 5'd15, 32'h1234_5678 + 32'd5);
        expect_write(18, 5'd16, 32'h50);
        expect_write(20, 5'd17, 32'h50);
        expect_write(21, 5'd18, 32'h50);
        expect_write(23, 5'd19, 32'd5);
        expect_write(25, 5'd20, 32'd1);
        expect_write(27, 5'd21, 32'd2);
        expect_write(30, 5'd23, 32'd3);
        expect_write(33, 5'd24, 32'd4);
        expect_write(35, 5'd25, 32'd5);
        expect_write(37, 5'd26, 32'd5 + 32'd1);
        expect_store(32'h100, 32'h1234_5678);
        expect_store(32'h104, 32'h50);
        expect_store(32'h108, 32'h50);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction ROM and data RAM with one-cycle read latency
    initial begin
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        forever begin
            @(negedge clk);
            i_en_q    = inst_sram_en;
            i_addr_q  = inst_sram_addr;
            d_en_q    = data_sram_en;
            d_wen_q   = data_sram_wen;
            d_addr_q  = data_sram_addr;
            d_wdata_q = data_sram_wdata;
            @(posedge clk);
            #2;
            if (i_en_q) begin
                inst_sram_rdata = rom_word(i_addr_q);
            end
            if (d_en_q) begin
                data_sram_rdata = dram[d_addr_q[11:2]];
                for (int b = 0; b < 4; b++) begin
                    if (d_wen_q[b]) begin
                        dram[d_addr_q[11:2]][8*b +: 8] = d_wdata_q[8*b +: 8];
                    end
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timeout after %0d cycles with %0d trace entries left",
                                    cycles, exp_trace.size()));
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (data_sram_wen != 4'h0) begin
                    if (stores_seen < exp_store.size()) begin
                        check_value("data_sram_en", {31'h0, data_sram_en}, 32'h1);
                        check_value("data_sram_wen", {28'h0, data_sram_wen}, 32'hf);
                        check_value("data_sram_addr", data_sram_addr,
                                    exp_store[stores_seen].addr);
                        check_value("data_sram_wdata", data_sram_wdata,
                                    exp_store[stores_seen].data);
                        stores_seen++;
                    end else begin
                        abort_run("A store reached the data SRAM that the program does not contain");
                    end
                end else if (data_sram_en) begin
                    loads_seen++;
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        build_expected();
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_value("inst_sram_en", {31'h0, inst_sram_en}, 32'h1);
        check_value("inst_sram_addr", inst_sram_addr, isa_pkg::RESET_VECTOR_DEFAULT);
        check_value("data_sram_en", {31'h0, data_sram_en}, 32'h0);
        check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'h0);
        @(posedge clk);
        #2 rst_n = 1'b1;

        for (int k = 0; k < exp_trace.size(); k++) begin
            do @(negedge clk); while (debug_wb_rf_wen == 4'h0);
            check_value("debug_wb_pc", debug_wb_pc, exp_trace[k].pc);
            check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'hf);
            check_value("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum}, {27'h0, exp_trace[k].num});
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_trace[k].value);
        end

        repeat (10) begin    // Nops only from here on
            @(negedge clk);
            if (debug_wb_rf_wen != 4'h0) begin
                abort_run($sformatf("Extra writeback at pc %h after the last expected entry",
                                    debug_wb_pc));
            end
        end
        check_value("store count", 32'(stores_seen), 32'(exp_store.size()));
        check_value("load count", 32'(loads_seen), 32'd3);

        $display("Verification passed");
        $finish;
    end

endmodule
